// ==== Makefile ====
# Verilator flow for the host glue testbench

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= tb_top
RTL_TOP   ?= a800_host_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/a800_host_top.sv ====
/*
 * Host glue top level: system ROM download and read path, load reset
 * and mouse joystick emulation, all on the system clock.
 */

`timescale 1ns/100ps

module a800_host_top import a800_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  areset,
	input  logic                  dl_active_i,
	input  logic [7:0]            dl_index_i,
	input  logic [OS_AW-1:0]      dl_addr_i,
	input  logic [7:0]            dl_data_i,
	input  logic                  dl_wr_i,
	input  logic                  boot_rom_off_i,
	input  logic [1:0]            machine_i,
	input  logic [CPU_ROM_AW-1:0] rom_addr_i,
	output logic [7:0]            rom_data_o,
	output logic                  load_reset_o,
	input  logic [24:0]           mouse_pkt_i,
	input  logic                  y_invert_i,
	input  logic [15:0]           analog_i,
	input  logic                  cpu_halt_i,
	input  logic [13:0]           joy_i,
	output logic [7:0]            axis_x_o,
	output logic [7:0]            axis_y_o,
	output logic [13:0]           joy_o,
	output logic                  mouse_active_o
);

	logic [7:0] xl_data;
	logic [7:0] basic_data;
	logic [7:0] osa_data;
	logic [7:0] osb_data;
	logic [3:0] bank_in_use;

	rom_load_if load_bus ();

	// ========================================
	// ROM subsystem
	// ========================================
	rom_load_decode u_decode (
		.clk_sys, .areset, .dl_active_i, .dl_index_i, .dl_addr_i, .dl_data_i,
		.dl_wr_i, .boot_rom_off_i, .bank_in_use_i(bank_in_use), .load(load_bus.source),
		.load_reset_o
	);

	rom_bank #(.AW(OS_AW), .BANK(ROM_XL)) u_xl (
		.clk_sys, .areset, .load(load_bus.sink),
		.rd_addr_i(rom_addr_i[OS_AW-1:0]), .rd_data_o(xl_data)
	);

	rom_bank #(.AW(BASIC_AW), .BANK(ROM_BASIC)) u_basic (
		.clk_sys, .areset, .load(load_bus.sink),
		.rd_addr_i(rom_addr_i[BASIC_AW-1:0]), .rd_data_o(basic_data)
	);

	rom_bank #(.AW(OS_AW), .BANK(ROM_OSA)) u_osa (
		.clk_sys, .areset, .load(load_bus.sink),
		.rd_addr_i(rom_addr_i[OS_AW-1:0]), .rd_data_o(osa_data)
	);

	rom_bank #(.AW(OS_AW), .BANK(ROM_OSB)) u_osb (
		.clk_sys, .areset, .load(load_bus.sink),
		.rd_addr_i(rom_addr_i[OS_AW-1:0]), .rd_data_o(osb_data)
	);

	rom_select u_select (
		.clk_sys, .areset, .machine_i(machine_e'(machine_i)), .rom_addr_i,
		.xl_data_i(xl_data), .basic_data_i(basic_data), .osa_data_i(osa_data),
		.osb_data_i(osb_data), .rom_data_o, .bank_in_use_o(bank_in_use)
	);

	// ========================================
	// Mouse emulation
	// ========================================
	mouse_axis u_mouse (
		.clk_sys, .areset, .mouse_pkt_i, .y_invert_i, .analog_i, .cpu_halt_i, .joy_i,
		.axis_x_o, .axis_y_o, .joy_o, .mouse_active_o
	);

endmodule

// ==== logic/a800_pkg.sv ====
/*
 * Shared constants and types for the host glue of the 8-bit computer core.
 * Every RTL block that needs a width, a bank or machine code, or one of the
 * reset and mouse limits imports this package with a wildcard.
 */

package a800_pkg;

	// ========================================
	// Address widths
	// ========================================
	localparam int OS_AW      = 14;
	localparam int BASIC_AW   = 13;
	localparam int CPU_ROM_AW = 15;

	// Read value of padded or unmapped ROM space
	localparam logic [7:0] PAD_BYTE = 8'hFF;

	// ROM bank identity, also the order of the in-use mask
	typedef enum logic [1:0] {
		ROM_XL    = 2'd0,
		ROM_BASIC = 2'd1,
		ROM_OSA   = 2'd2,
		ROM_OSB   = 2'd3
	} rom_bank_e;

	// Machine selection as it arrives on the 2-bit input
	typedef enum logic [1:0] {
		MACH_XL_BASIC = 2'd0,
		MACH_XL       = 2'd1,
		MACH_OS_A_800 = 2'd2,
		MACH_OS_B_800 = 2'd3
	} machine_e;

	// ========================================
	// Load reset and mouse limits
	// ========================================
	localparam int LOAD_RESET_CYCLES = 64;
	localparam int LOAD_CNT_W        = $clog2(LOAD_RESET_CYCLES);

	localparam int MOUSE_STEP_MAX = 10;
	localparam int AXIS_MIN       = -128;
	localparam int AXIS_MAX       = 127;

endpackage

// ==== logic/mouse_axis.sv ====
/*
 * Mouse emulation of the analog joystick axes and fire buttons.
 * Each mouse packet moves two clamped accumulators; any analog stick
 * activity or a CPU halt hands the outputs back to the real inputs.
 */

`timescale 1ns/100ps

module mouse_axis import a800_pkg::*; (
	input  logic        clk_sys,
	input  logic        areset,
	input  logic [24:0] mouse_pkt_i,
	input  logic        y_invert_i,
	input  logic [15:0] analog_i,
	input  logic        cpu_halt_i,
	input  logic [13:0] joy_i,
	output logic [7:0]  axis_x_o,
	output logic [7:0]  axis_y_o,
	output logic [13:0] joy_o,
	output logic        mouse_active_o
);

	logic signed [8:0] dx_raw;
	logic signed [8:0] dy_raw;
	logic signed [8:0] dx_lim;
	logic signed [8:0] dy_lim;
	logic signed [9:0] nx;
	logic signed [9:0] ny;
	logic signed [8:0] mx_q;
	logic signed [8:0] my_q;
	logic              stb_q;

	function automatic logic signed [8:0] clamp(input logic signed [9:0] v,
			input int lo, input int hi);
		if (v < lo)
			return 9'(lo);
		if (v > hi)
			return 9'(hi);
		return v[8:0];
	endfunction

	// Packet deltas are 9-bit two's complement with a separate sign bit
	assign dx_raw = {mouse_pkt_i[4], mouse_pkt_i[15:8]};
	assign dy_raw = {mouse_pkt_i[5], mouse_pkt_i[23:16]};
	assign dx_lim = clamp(10'(dx_raw), -MOUSE_STEP_MAX, MOUSE_STEP_MAX);
	assign dy_lim = clamp(10'(dy_raw), -MOUSE_STEP_MAX, MOUSE_STEP_MAX);

	assign nx = mx_q + dx_lim;
	assign ny = y_invert_i ? (my_q - dy_lim) : (my_q + dy_lim);

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_q          <= 1'b0;
			mouse_active_o <= 1'b0;
			mx_q           <= '0;
			my_q           <= '0;
		end else begin
			stb_q <= mouse_pkt_i[24];
			if (stb_q != mouse_pkt_i[24]) begin
				mouse_active_o <= 1'b1;
				mx_q           <= clamp(nx, AXIS_MIN, AXIS_MAX);
				my_q           <= clamp(ny, AXIS_MIN, AXIS_MAX);
			end
			// Real stick or halted CPU wins over a new packet
			if (analog_i != 16'd0 || cpu_halt_i) begin
				mouse_active_o <= 1'b0;
				mx_q           <= '0;
				my_q           <= '0;
			end
		end
	end

	assign axis_x_o = mouse_active_o ? mx_q[7:0] : analog_i[7:0];
	assign axis_y_o = mouse_active_o ? my_q[7:0] : analog_i[15:8];
	assign joy_o    = {joy_i[13:9], mouse_active_o ? mouse_pkt_i[1:0] : joy_i[8:7], joy_i[6:0]};

	a_axis_range: assert property (@(posedge clk_sys) disable iff (areset)
		mx_q >= AXIS_MIN && mx_q <= AXIS_MAX && my_q >= AXIS_MIN && my_q <= AXIS_MAX);

endmodule

// ==== logic/rom_bank.sv ====
/*
 * One dual-port system ROM bank fed from the load bus.
 * Top-aligned banks track the image length so that a short image ends at
 * the top of the window; reads below it return the pad byte. Read data
 * follows the read address by one clock.
 */

`timescale 1ns/100ps

module rom_bank import a800_pkg::*; #(
	parameter int        AW   = OS_AW,
	parameter rom_bank_e BANK = ROM_XL
) (
	input  logic          clk_sys,
	input  logic          areset,
	rom_load_if.sink      load,
	input  logic [AW-1:0] rd_addr_i,
	output logic [7:0]    rd_data_o
);

	// BASIC sits at the bottom of its window
	localparam bit ALIGN = (BANK != ROM_BASIC);

	logic [7:0]    mem [2**AW];
	logic [AW-1:0] offset_q;
	logic          bank_wr;
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] mem_addr;
	logic          pad;
	logic [7:0]    rd_q;
	logic          pad_q;

	assign bank_wr = load.wr && (load.bank == BANK);
	assign wr_addr = load.addr[AW-1:0];

	always_ff @(posedge clk_sys) begin
		if (bank_wr)
			mem[wr_addr] <= load.data;
	end

	// Last written address gives the distance to the window top
	always_ff @(posedge clk_sys) begin
		if (areset)
			offset_q <= '0;
		else if (bank_wr && ALIGN)
			offset_q <= {AW{1'b1}} - wr_addr;
	end

	// Read side shift and pad decision
	assign pad      = (rd_addr_i < offset_q);
	assign mem_addr = rd_addr_i - offset_q;

	always_ff @(posedge clk_sys) begin
		rd_q  <= mem[mem_addr];
		pad_q <= pad;
	end

	assign rd_data_o = pad_q ? PAD_BYTE : rd_q;

endmodule

// ==== logic/rom_load_decode.sv ====
/*
 * Download index decoder and cold-reset generator.
 * Turns each download strobe into a bank write on the load bus, and after a
 * download that replaced an in-use system ROM raises load_reset_o for a
 * fixed number of clocks.
 */

`timescale 1ns/100ps

module rom_load_decode import a800_pkg::*; (
	input  logic             clk_sys,
	input  logic             areset,
	input  logic             dl_active_i,
	input  logic [7:0]       dl_index_i,
	input  logic [OS_AW-1:0] dl_addr_i,
	input  logic [7:0]       dl_data_i,
	input  logic             dl_wr_i,
	input  logic             boot_rom_off_i,
	input  logic [3:0]       bank_in_use_i,
	rom_load_if.source       load,
	output logic             load_reset_o
);

	logic                  sys_idx;
	logic                  boot_idx;
	logic                  active_q;
	logic                  dl_end;
	logic                  hit_q;
	logic                  start_q;
	logic [LOAD_CNT_W-1:0] cnt_q;

	// ========================================
	// Index decode
	// ========================================
	// Indices x4..x7 name a bank in their low bits
	assign sys_idx  = (dl_index_i[5:2] == 4'b0001);
	// Boot images use the top two bits, only while boot ROMs are enabled
	assign boot_idx = !boot_rom_off_i && (dl_index_i[5:0] == 6'd0);

	assign load.bank = sys_idx ? rom_bank_e'(dl_index_i[1:0]) : rom_bank_e'(dl_index_i[7:6]);
	assign load.wr   = dl_wr_i && (sys_idx || boot_idx);
	assign load.addr = dl_addr_i;
	assign load.data = dl_data_i;

	// ========================================
	// Load reset
	// ========================================
	assign dl_end = active_q && !dl_active_i;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			active_q     <= 1'b0;
			hit_q        <= 1'b0;
			start_q      <= 1'b0;
			cnt_q        <= '0;
			load_reset_o <= 1'b0;
		end else begin
			active_q <= dl_active_i;
			start_q  <= dl_end && hit_q;

			// Remember a write into a bank the running machine depends on
			if (dl_end)
				hit_q <= 1'b0;
			else if (load.wr && bank_in_use_i[load.bank])
				hit_q <= 1'b1;

			if (start_q) begin
				load_reset_o <= 1'b1;
				cnt_q        <= LOAD_CNT_W'(LOAD_RESET_CYCLES - 1);
			end else if (load_reset_o) begin
				if (cnt_q == '0)
					load_reset_o <= 1'b0;
				else
					cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	// Host only strobes writes inside a download
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (areset)
		load.wr |-> dl_active_i);

endmodule

// ==== logic/rom_load_if.sv ====
/*
 * One decoded download write on its way to the ROM banks.
 * The decoder drives it through source, every bank listens through sink
 * and picks the strobes that carry its own bank code.
 */

`timescale 1ns/100ps

interface rom_load_if import a800_pkg::*; ();

	logic [OS_AW-1:0] addr;
	logic [7:0]       data;
	logic             wr;
	rom_bank_e        bank;

	modport source (
		output addr,
		output data,
		output wr,
		output bank
	);

	modport sink (
		input addr,
		input data,
		input wr,
		input bank
	);

endinterface

// ==== logic/rom_select.sv ====
/*
 * CPU ROM read multiplexer.
 * Latches the machine type while reset is held, delays the upper address
 * bits to line up with the bank read stage, and picks the bank output.
 * Also reports which banks the latched machine type depends on.
 */

`timescale 1ns/100ps

module rom_select import a800_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  areset,
	input  machine_e              machine_i,
	input  logic [CPU_ROM_AW-1:0] rom_addr_i,
	input  logic [7:0]            xl_data_i,
	input  logic [7:0]            basic_data_i,
	input  logic [7:0]            osa_data_i,
	input  logic [7:0]            osb_data_i,
	output logic [7:0]            rom_data_o,
	output logic [3:0]            bank_in_use_o
);

	machine_e   sel_q;
	logic [1:0] addr_hi_q;

	// Machine type only changes across a reset
	always_ff @(posedge clk_sys) begin
		if (areset)
			sel_q <= machine_i;
	end

	// Same stage as the bank read registers
	always_ff @(posedge clk_sys) begin
		addr_hi_q <= rom_addr_i[CPU_ROM_AW-1:CPU_ROM_AW-2];
	end

	// ========================================
	// Read mux
	// ========================================
	always_comb begin
		if (addr_hi_q == 2'b00 && sel_q == MACH_XL_BASIC)
			rom_data_o = basic_data_i;
		else if (addr_hi_q[1] && (sel_q == MACH_XL || sel_q == MACH_XL_BASIC))
			rom_data_o = xl_data_i;
		else if (addr_hi_q[1])
			rom_data_o = (sel_q == MACH_OS_B_800) ? osb_data_i : osa_data_i;
		else
			rom_data_o = PAD_BYTE;
	end

	// In-use mask indexed by bank code
	always_comb begin
		bank_in_use_o = 4'b0000;
		case (sel_q)
			MACH_XL_BASIC: begin
				bank_in_use_o[ROM_XL]    = 1'b1;
				bank_in_use_o[ROM_BASIC] = 1'b1;
			end
			MACH_XL:       bank_in_use_o[ROM_XL]  = 1'b1;
			MACH_OS_A_800: bank_in_use_o[ROM_OSA] = 1'b1;
			MACH_OS_B_800: bank_in_use_o[ROM_OSB] = 1'b1;
		endcase
	end

endmodule

// ==== tb/tb_checker.sv ====
/*
 * Checker for the host glue testbench.
 * Mirrors downloads into model banks, predicts ROM reads, the cold-reset
 * pulse and the mouse outputs, and compares them with the DUT every clock.
 */

`timescale 1ns/100ps

module tb_checker import a800_pkg::*; (
	input logic                  clk_sys,
	input logic                  areset,
	input logic                  dl_active_i,
	input logic [7:0]            dl_index_i,
	input logic [OS_AW-1:0]      dl_addr_i,
	input logic [7:0]            dl_data_i,
	input logic                  dl_wr_i,
	input logic                  boot_rom_off_i,
	input logic [1:0]            machine_i,
	input logic [CPU_ROM_AW-1:0] rom_addr_i,
	input logic                  rd_valid_i,
	input logic [7:0]            rom_data_o,
	input logic                  load_reset_o,
	input logic [24:0]           mouse_pkt_i,
	input logic                  y_invert_i,
	input logic [15:0]           analog_i,
	input logic                  cpu_halt_i,
	input logic [13:0]           joy_i,
	input logic [7:0]            axis_x_o,
	input logic [7:0]            axis_y_o,
	input logic [13:0]           joy_o,
	input logic                  mouse_active_o
);

	logic [7:0]       mem [4][2**OS_AW];
	logic [OS_AW-1:0] offs [4];
	logic [1:0]       mach;
	logic [1:0]       wr_bank;
	logic [7:0]       rd_exp;
	bit               rd_pend;
	bit               active_prev;
	bit               hit;
	bit               lr_arm;
	bit               stb_prev;
	bit               act;
	int               lr_left;
	int               mx;
	int               my;
	int               dx;
	int               dy;
	int               n_checks = 0;
	int               n_errors = 0;

	function automatic int clamp_int(input int v, input int lo, input int hi);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	function automatic bit target_bank(input logic [7:0] idx, input logic boot_off,
			output logic [1:0] b);
		b = idx[1:0];
		if (idx[5:2] == 4'b0001)
			return 1'b1;
		b = idx[7:6];
		return !boot_off && idx[5:0] == 6'd0;
	endfunction

	function automatic bit in_use(input logic [1:0] b);
		case (mach)
			MACH_XL_BASIC: return b == ROM_XL || b == ROM_BASIC;
			MACH_XL:       return b == ROM_XL;
			MACH_OS_A_800: return b == ROM_OSA;
			default:       return b == ROM_OSB;
		endcase
	endfunction

	// Top-aligned bank view, pad byte below the image
	function automatic logic [7:0] bank_read(input logic [1:0] b, input logic [OS_AW-1:0] a);
		if (a < offs[b])
			return PAD_BYTE;
		return mem[b][a - offs[b]];
	endfunction

	// Expected CPU ROM byte for the latched machine type
	function automatic logic [7:0] expected_rom(input logic [CPU_ROM_AW-1:0] a);
		if (a[14:13] == 2'b00 && mach == MACH_XL_BASIC)
			return bank_read(ROM_BASIC, {1'b0, a[12:0]});
		if (a[14] && (mach == MACH_XL || mach == MACH_XL_BASIC))
			return bank_read(ROM_XL, a[13:0]);
		if (a[14])
			return bank_read(mach[0] ? ROM_OSB : ROM_OSA, a[13:0]);
		return PAD_BYTE;
	endfunction

	task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	always @(posedge clk_sys) begin
		if (areset) begin
			mach        = machine_i;
			offs        = '{default: '0};
			rd_pend     = 1'b0;
			active_prev = 1'b0;
			hit         = 1'b0;
			lr_arm      = 1'b0;
			lr_left     = 0;
			stb_prev    = 1'b0;
			act         = 1'b0;
			mx          = 0;
			my          = 0;
		end else begin
			// ========================================
			// Compare outputs settled since the last edge
			// ========================================
			if (rd_pend)
				check("rom_data_o", rom_data_o, rd_exp);
			check("load_reset_o", load_reset_o, lr_left > 0);
			check("mouse_active_o", mouse_active_o, act);
			check("axis_x_o", axis_x_o, act ? 8'(mx) : analog_i[7:0]);
			check("axis_y_o", axis_y_o, act ? 8'(my) : analog_i[15:8]);
			check("joy_o", joy_o, act ? {joy_i[13:9], mouse_pkt_i[1:0], joy_i[6:0]} : joy_i);

			// Read sees the banks as they stood before this edge
			rd_pend = rd_valid_i;
			if (rd_valid_i)
				rd_exp = expected_rom(rom_addr_i);

			// Pulse starts on the second edge after the download ends
			if (lr_left > 0)
				lr_left--;
			if (lr_arm)
				lr_left = LOAD_RESET_CYCLES;
			lr_arm = active_prev && !dl_active_i && hit;
			if (active_prev && !dl_active_i)
				hit = 1'b0;
			active_prev = dl_active_i;

			// Download mirror
			if (dl_wr_i && target_bank(dl_index_i, boot_rom_off_i, wr_bank)) begin
				if (wr_bank == ROM_BASIC) begin
					mem[wr_bank][dl_addr_i & 14'h1FFF] = dl_data_i;
				end else begin
					mem[wr_bank][dl_addr_i] = dl_data_i;
					offs[wr_bank] = 14'h3FFF - dl_addr_i;
				end
				if (in_use(wr_bank))
					hit = 1'b1;
			end

			// Mouse accumulation
			if (stb_prev != mouse_pkt_i[24]) begin
				dx  = clamp_int($signed({mouse_pkt_i[4], mouse_pkt_i[15:8]}),
					-MOUSE_STEP_MAX, MOUSE_STEP_MAX);
				dy  = clamp_int($signed({mouse_pkt_i[5], mouse_pkt_i[23:16]}),
					-MOUSE_STEP_MAX, MOUSE_STEP_MAX);
				act = 1'b1;
				mx  = clamp_int(mx + dx, AXIS_MIN, AXIS_MAX);
				my  = clamp_int(y_invert_i ? my - dy : my + dy, AXIS_MIN, AXIS_MAX);
			end
			if (analog_i != 16'd0 || cpu_halt_i) begin
				act = 1'b0;
				mx  = 0;
				my  = 0;
			end
			stb_prev = mouse_pkt_i[24];
		end
	end

endmodule

// ==== tb/tb_top.sv ====
/*
 * Top of the host glue testbench.
 * Makes clock and reset, drives LFSR stimulus on the falling edge through
 * ROM downloads, ROM reads and mouse traffic, and reports the verdict
 * from the checker's error count at the end.
 */

`timescale 1ns/100ps

module tb_top import a800_pkg::*; ();

	localparam logic [31:0] SEED  = 32'h49fe2528;
	localparam logic [31:0] TAPS  = 32'h80200003;
	localparam int N_READS        = 300;
	localparam int N_MOUSE        = 200;
	localparam int MAX_IMG        = 64 + 1023;
	localparam int DL_CYCLES      = 512 + 3 * MAX_IMG + 4 * (LOAD_RESET_CYCLES + 8);
	localparam int WATCHDOG_CYCLES = 6 * (DL_CYCLES + N_READS + 8) + 2 * (N_MOUSE + 40) + 200;

	logic                  clk_sys;
	logic                  areset;
	logic                  dl_active_i;
	logic [7:0]            dl_index_i;
	logic [OS_AW-1:0]      dl_addr_i;
	logic [7:0]            dl_data_i;
	logic                  dl_wr_i;
	logic                  boot_rom_off_i;
	logic [1:0]            machine_i;
	logic [CPU_ROM_AW-1:0] rom_addr_i;
	logic                  rd_valid_i;
	logic [7:0]            rom_data_o;
	logic                  load_reset_o;
	logic [24:0]           mouse_pkt_i;
	logic                  y_invert_i;
	logic [15:0]           analog_i;
	logic                  cpu_halt_i;
	logic [13:0]           joy_i;
	logic [7:0]            axis_x_o;
	logic [7:0]            axis_y_o;
	logic [13:0]           joy_o;
	logic                  mouse_active_o;
	logic [31:0]           lfsr;

	a800_host_top dut0 (.*);
	tb_checker chk0 (.*);

	always #10 clk_sys = ~clk_sys;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ TAPS) : (lfsr >> 1);
			r[i] = lfsr[0];
		end
		return r;
	endfunction

	function automatic int image_length();
		return 64 + int'(rand_bits(10));
	endfunction

	task automatic apply_reset(input logic [1:0] mach);
		@(negedge clk_sys);
		machine_i = mach;
		areset    = 1'b1;
		repeat (3) @(negedge clk_sys);
		areset = 1'b0;
	endtask

	// One image, then wait until any cold-reset pulse is over
	task automatic download(input logic [7:0] idx, input int len, input logic boot_off);
		@(negedge clk_sys);
		boot_rom_off_i = boot_off;
		dl_index_i     = idx;
		dl_active_i    = 1'b1;
		for (int a = 0; a < len; a++) begin
			@(negedge clk_sys);
			dl_addr_i = OS_AW'(a);
			dl_data_i = 8'(rand_bits(8));
			dl_wr_i   = 1'b1;
		end
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		@(negedge clk_sys);
		dl_active_i = 1'b0;
		repeat (3) @(negedge clk_sys);
		while (load_reset_o)
			@(negedge clk_sys);
	endtask

	// Back-to-back reads, biased toward the loaded top of each window
	task automatic run_reads(input int n);
		logic [CPU_ROM_AW-1:0] a;
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
			a = CPU_ROM_AW'(rand_bits(CPU_ROM_AW));
			if (rand_bits(1) != 0)
				a[13:10] = 4'hF;
			if (a[14:13] == 2'b00)
				a[12:9] = 4'h0;
			rom_addr_i = a;
			rd_valid_i = 1'b1;
		end
		@(negedge clk_sys);
		rd_valid_i = 1'b0;
	endtask

	task automatic mouse_moves(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
			mouse_pkt_i[23:0] = 24'(rand_bits(24));
			if (rand_bits(1) != 0)
				mouse_pkt_i[24] = ~mouse_pkt_i[24];
			y_invert_i = rand_bits(1) != 0;
			joy_i      = 14'(rand_bits(14));
		end
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		clk_sys        = 1'b0;
		areset         = 1'b1;
		dl_active_i    = 1'b0;
		dl_index_i     = '0;
		dl_addr_i      = '0;
		dl_data_i      = '0;
		dl_wr_i        = 1'b0;
		boot_rom_off_i = 1'b1;
		machine_i      = '0;
		rom_addr_i     = '0;
		rd_valid_i     = 1'b0;
		mouse_pkt_i    = '0;
		y_invert_i     = 1'b0;
		analog_i       = '0;
		cpu_halt_i     = 1'b0;
		joy_i          = '0;
		lfsr           = SEED;

		// All four images under every machine type
		for (int m = 0; m < 4; m++) begin
			apply_reset(2'(m));
			download(8'h05, 512, 1'b1);
			download(8'h04, image_length(), 1'b1);
			download(8'h06, image_length(), 1'b1);
			download(8'h07, image_length(), 1'b1);
			run_reads(N_READS);
		end

		// Boot index ignored while boot ROMs are off, taken when on
		download(8'hC0, image_length(), 1'b1);
		run_reads(N_READS);
		download(8'hC0, image_length(), 1'b0);
		download(8'h40, 256, 1'b0);
		run_reads(N_READS);

		// Mouse, then real stick and CPU halt take over
		mouse_moves(N_MOUSE);
		@(negedge clk_sys);
		analog_i = 16'(rand_bits(16)) | 16'h0100;
		mouse_moves(8);
		@(negedge clk_sys);
		analog_i = '0;
		mouse_moves(N_MOUSE / 4);
		@(negedge clk_sys);
		cpu_halt_i = 1'b1;
		mouse_moves(4);
		@(negedge clk_sys);
		cpu_halt_i = 1'b0;
		mouse_pkt_i[24] = ~mouse_pkt_i[24];
		repeat (4) @(negedge clk_sys);

		$display("Checks: %0d, errors: %0d", chk0.n_checks, chk0.n_errors);
		if (chk0.n_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
logic/a800_pkg.sv
logic/rom_load_if.sv
logic/rom_load_decode.sv
logic/rom_bank.sv
logic/rom_select.sv
logic/mouse_axis.sv
logic/a800_host_top.sv
tb/tb_checker.sv
tb/tb_top.sv
